// File: Bender.yml
package:
  name: ahb_switch

sources:
  - design/ahbSwitchPkg.sv
  - design/ahbArbiter.sv
  - design/ahbSlavePort.sv
  - design/ahbMasterPort.sv
  - design/ahbSwitch.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/ahbSwitchTb.sv

// File: design/ahbArbiter.sv
// Fixed-priority arbiter that hands out the grant of one slave bus
`timescale 1ns/100ps
`default_nettype none

module ahbArbiter #(
  parameter int NumMasters = 2
) (
  input  wire                   HCLK,
  input  wire                   arstN,
  input  wire  [NumMasters-1:0] request,
  input  wire  [NumMasters-1:0] canSwitch,
  input  wire                   busReady,
  output logic [NumMasters-1:0] grant
);

  logic [NumMasters-1:0] pick;
  logic                  ownerFree;
  logic                  update;

  // Lowest index wins, so master 0 has top priority
  // Walk downwards and let the last hit overwrite
  always_comb
  begin
    pick = '0;
    for (int m = NumMasters - 1; m >= 0; m--)
    begin
      if (request[m])
      begin
        pick    = '0;
        pick[m] = 1'b1;
      end
    end
  end

  // An empty grant is always free to move
  assign ownerFree = (grant == '0) || |(grant & canSwitch);

  // Only move on a ready bus, otherwise an address phase would be dropped
  // With no requester the grant stays parked on the last owner
  assign update = ownerFree && busReady && |request;

  //////////////////////////////
  // Grant register
  //////////////////////////////

  always_ff @(posedge HCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      grant <= '0;
    end
    else if (update)
    begin
      grant <= pick;
    end
  end

  // Two owners would drive the same slave bus
  assert property (@(posedge HCLK) disable iff (!arstN) $onehot0(grant))
    else $error("ahbArbiter: grant is not one-hot");

endmodule

`default_nettype wire

// File: design/ahbMasterPort.sv
// Master-side port with address decode, stalled phase buffer and response routing
`timescale 1ns/100ps
`default_nettype none

module ahbMasterPort #(
  parameter int NumSlaves = 2,
  parameter logic [NumSlaves-1:0][ahbSwitchPkg::AddrWidth-1:0] SlaveBase = '0,
  parameter logic [NumSlaves-1:0][ahbSwitchPkg::AddrWidth-1:0] SlaveMask = '0
) (
  input  wire                                 HCLK,
  input  wire                                 arstN,

  // AHB bus from the master
  input  wire                                 mstHsel,
  input  wire  ahbSwitchPkg::ahbReqT          mstReq,
  input  wire  [ahbSwitchPkg::DataWidth-1:0]  mstHwdata,
  input  wire                                 mstHready,
  output ahbSwitchPkg::ahbRespT               mstResp,

  // Towards the slave ports
  output logic [NumSlaves-1:0]                slvSel,
  output ahbSwitchPkg::ahbReqT                slvReq,
  output logic [ahbSwitchPkg::DataWidth-1:0]  slvHwdata,
  output logic                                canSwitch,

  // From the slave ports
  input  wire  [NumSlaves-1:0]                granted,
  input  wire  ahbSwitchPkg::ahbRespT         slvResp [NumSlaves]
);

  logic                 transValid;
  logic                 liveValid;
  logic                 curValid;
  ahbSwitchPkg::ahbReqT curReq;
  logic [NumSlaves-1:0] hit;
  logic [NumSlaves-1:0] acceptSel;
  logic                 accepted;
  logic                 pendValid;
  ahbSwitchPkg::ahbReqT pendReq;
  logic [NumSlaves-1:0] dataSel;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  // IDLE and BUSY carry no transfer
  assign transValid = (mstReq.trans == ahbSwitchPkg::TransNonseq) ||
                      (mstReq.trans == ahbSwitchPkg::TransSeq);

  // Live phase, accepted from the master on this edge
  assign liveValid = mstHsel && mstHready && transValid;

  // A buffered phase goes first, the master is stalled meanwhile
  assign curReq   = pendValid ? pendReq : mstReq;
  assign curValid = pendValid || liveValid;

  // Static base and mask per region
  always_comb
  begin
    for (int s = 0; s < NumSlaves; s++)
    begin
      hit[s] = (curReq.addr & SlaveMask[s]) == (SlaveBase[s] & SlaveMask[s]);
    end
  end

  assign slvSel    = curValid ? hit : '0;
  assign slvReq    = curReq;
  assign slvHwdata = mstHwdata;

  // Slave port takes the phase on this edge
  assign acceptSel = slvSel & granted;
  assign accepted  = |acceptSel;

  // Hold the slave grant through a SEQ or BUSY run
  // A stalled port gives it up so two ports never wait on each other
  assign canSwitch = pendValid ||
                     !(mstHsel && ((mstReq.trans == ahbSwitchPkg::TransSeq) ||
                                   (mstReq.trans == ahbSwitchPkg::TransBusy)));

  //////////////////////////////
  // Stalled phase buffer
  //////////////////////////////

  // Load on a decoded phase the slave did not take, clear once it does
  always_ff @(posedge HCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      pendValid <= 1'b0;
    end
    else if (pendValid)
    begin
      if (accepted)
      begin
        pendValid <= 1'b0;
      end
    end
    else if (liveValid && |hit && !accepted)
    begin
      pendValid <= 1'b1;
    end
  end

  // Address phase captured from the master for replay
  always_ff @(posedge HCLK)
  begin
    if (!pendValid && liveValid)
    begin
      pendReq <= mstReq;
    end
  end

  //////////////////////////////
  // Data phase
  //////////////////////////////

  // One-hot slave owning our data phase, zero for none or unmapped
  always_ff @(posedge HCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      dataSel <= '0;
    end
    else if (pendValid)
    begin
      if (accepted)
      begin
        dataSel <= acceptSel;
      end
    end
    else if (mstResp.ready)
    begin
      dataSel <= acceptSel;
    end
  end

  // Unmapped or idle ends as a zero-wait OKAY
  always_comb
  begin
    mstResp.rdata = '0;
    mstResp.ready = 1'b1;
    mstResp.resp  = ahbSwitchPkg::RespOkay;
    for (int s = 0; s < NumSlaves; s++)
    begin
      if (dataSel[s])
      begin
        mstResp = slvResp[s];
      end
    end
    if (pendValid)
    begin
      mstResp.ready = 1'b0;
      mstResp.resp  = ahbSwitchPkg::RespOkay;
    end
  end

  // Master must stay stalled until its buffered phase has been served
  assert property (@(posedge HCLK) disable iff (!arstN) pendValid |-> !mstResp.ready)
    else $error("ahbMasterPort: ready high with a phase pending");

endmodule

`default_nettype wire

// File: design/ahbSlavePort.sv
// Slave-side port that arbitrates one slave bus and routes its data phase
`timescale 1ns/100ps
`default_nettype none

module ahbSlavePort #(
  parameter int NumMasters = 2
) (
  input  wire                                 HCLK,
  input  wire                                 arstN,

  // From the master ports
  input  wire  [NumMasters-1:0]               mstSel,
  input  wire  ahbSwitchPkg::ahbReqT          mstReq    [NumMasters],
  input  wire  [ahbSwitchPkg::DataWidth-1:0]  mstHwdata [NumMasters],
  input  wire  [NumMasters-1:0]               canSwitch,

  // Back to the master ports
  output logic [NumMasters-1:0]               grant,
  output ahbSwitchPkg::ahbRespT               mstResp,

  // Slave bus
  output logic                                slvHsel,
  output ahbSwitchPkg::ahbReqT                slvReq,
  output logic [ahbSwitchPkg::DataWidth-1:0]  slvHwdata,
  output logic                                slvHreadyout,
  input  wire  [ahbSwitchPkg::DataWidth-1:0]  slvHrdata,
  input  wire                                 slvHready,
  input  wire                                 slvHresp
);

  logic [NumMasters-1:0] arbGrant;
  logic [NumMasters-1:0] owner;
  logic                  accept;

  ahbArbiter #(
    .NumMasters (NumMasters)
  ) u_ahbArbiter (
    .HCLK      (HCLK),
    .arstN     (arstN),
    .request   (mstSel),
    .canSwitch (canSwitch),
    .busReady  (slvHready),
    .grant     (arbGrant)
  );

  //////////////////////////////
  // Address phase
  //////////////////////////////

  // Granted master drives the bus straight through, no register
  always_comb
  begin
    slvReq  = '0;
    slvHsel = 1'b0;
    for (int m = 0; m < NumMasters; m++)
    begin
      if (arbGrant[m])
      begin
        slvReq  = mstReq[m];
        slvHsel = mstSel[m];
      end
    end
    // Parked owner aiming elsewhere, keep the bus idle
    if (!slvHsel)
    begin
      slvReq.trans = ahbSwitchPkg::TransIdle;
    end
  end

  // Master ports see the grant only when the slave takes the phase now
  assign grant = arbGrant & {NumMasters{slvHready}};

  // Single slave on this bus, its HREADYOUT is the bus HREADY
  assign slvHreadyout = slvHready;

  assign accept = slvHsel && slvHready;

  //////////////////////////////
  // Data phase
  //////////////////////////////

  // Owner follows the accepted address phase by one cycle
  // and drops back to none once the data phase ends
  always_ff @(posedge HCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      owner <= '0;
    end
    else if (slvHready)
    begin
      owner <= accept ? arbGrant : '0;
    end
  end

  // Write data comes from whoever owns the data phase
  always_comb
  begin
    slvHwdata = '0;
    for (int m = 0; m < NumMasters; m++)
    begin
      if (owner[m])
      begin
        slvHwdata = mstHwdata[m];
      end
    end
  end

  // Without a data phase in flight this slave looks ready and OKAY
  assign mstResp.rdata = slvHrdata;
  assign mstResp.ready = (owner != '0) ? slvHready : 1'b1;
  assign mstResp.resp  = (owner != '0) ? slvHresp : ahbSwitchPkg::RespOkay;

  // A selected bus must come from exactly one arbitration winner
  assert property (@(posedge HCLK) disable iff (!arstN) slvHsel |-> $onehot(arbGrant))
    else $error("ahbSlavePort: slvHsel without a single grant");

endmodule

`default_nettype wire

// File: design/ahbSwitch.sv
// AHB-Lite multi-layer switch top joining master ports and slave ports
`timescale 1ns/100ps
`default_nettype none

module ahbSwitch #(
  parameter int NumMasters = 2,
  parameter int NumSlaves  = 2,
  parameter logic [NumSlaves-1:0][ahbSwitchPkg::AddrWidth-1:0] SlaveBase =
    {32'h1000_0000, 32'h0000_0000},
  parameter logic [NumSlaves-1:0][ahbSwitchPkg::AddrWidth-1:0] SlaveMask =
    {32'hF000_0000, 32'hF000_0000}
) (
  input  wire                                 HCLK,
  input  wire                                 arstN,

  // Master-side buses
  input  wire                                 mstHsel      [NumMasters],
  input  wire  ahbSwitchPkg::ahbReqT          mstReq       [NumMasters],
  input  wire  [ahbSwitchPkg::DataWidth-1:0]  mstHwdata    [NumMasters],
  input  wire                                 mstHready    [NumMasters],
  output ahbSwitchPkg::ahbRespT               mstResp      [NumMasters],

  // Slave-side buses
  output logic                                slvHsel      [NumSlaves],
  output ahbSwitchPkg::ahbReqT                slvReq       [NumSlaves],
  output logic [ahbSwitchPkg::DataWidth-1:0]  slvHwdata    [NumSlaves],
  output logic                                slvHreadyout [NumSlaves],
  input  wire  [ahbSwitchPkg::DataWidth-1:0]  slvHrdata    [NumSlaves],
  input  wire                                 slvHready    [NumSlaves],
  input  wire                                 slvHresp     [NumSlaves]
);

  // Master port side, indexed by master
  logic [NumSlaves-1:0]               selFromMst    [NumMasters];
  ahbSwitchPkg::ahbReqT               reqFromMst    [NumMasters];
  logic [ahbSwitchPkg::DataWidth-1:0] wdataFromMst  [NumMasters];
  logic                               switchFromMst [NumMasters];
  logic [NumSlaves-1:0]               grantToMst    [NumMasters];

  // Slave port side, indexed by slave
  logic [NumMasters-1:0]              selToSlv      [NumSlaves];
  logic [NumMasters-1:0]              grantFromSlv  [NumSlaves];
  ahbSwitchPkg::ahbRespT              respFromSlv   [NumSlaves];
  logic [NumMasters-1:0]              switchToSlv;

  //////////////////////////////
  // Crossing
  //////////////////////////////

  // Select and grant swap their master and slave index
  always_comb
  begin
    for (int s = 0; s < NumSlaves; s++)
    begin
      for (int m = 0; m < NumMasters; m++)
      begin
        selToSlv[s][m]   = selFromMst[m][s];
        grantToMst[m][s] = grantFromSlv[s][m];
      end
    end
    for (int m = 0; m < NumMasters; m++)
    begin
      switchToSlv[m] = switchFromMst[m];
    end
  end

  //////////////////////////////
  // Ports
  //////////////////////////////

  for (genvar m = 0; m < NumMasters; m++)
  begin : gMasterPort
    ahbMasterPort #(
      .NumSlaves (NumSlaves),
      .SlaveBase (SlaveBase),
      .SlaveMask (SlaveMask)
    ) u_ahbMasterPort (
      .HCLK      (HCLK),
      .arstN     (arstN),
      .mstHsel   (mstHsel[m]),
      .mstReq    (mstReq[m]),
      .mstHwdata (mstHwdata[m]),
      .mstHready (mstHready[m]),
      .mstResp   (mstResp[m]),
      .slvSel    (selFromMst[m]),
      .slvReq    (reqFromMst[m]),
      .slvHwdata (wdataFromMst[m]),
      .canSwitch (switchFromMst[m]),
      .granted   (grantToMst[m]),
      .slvResp   (respFromSlv)
    );
  end

  // Every slave port sees all master requests and write data
  for (genvar s = 0; s < NumSlaves; s++)
  begin : gSlavePort
    ahbSlavePort #(
      .NumMasters (NumMasters)
    ) u_ahbSlavePort (
      .HCLK         (HCLK),
      .arstN        (arstN),
      .mstSel       (selToSlv[s]),
      .mstReq       (reqFromMst),
      .mstHwdata    (wdataFromMst),
      .canSwitch    (switchToSlv),
      .grant        (grantFromSlv[s]),
      .mstResp      (respFromSlv[s]),
      .slvHsel      (slvHsel[s]),
      .slvReq       (slvReq[s]),
      .slvHwdata    (slvHwdata[s]),
      .slvHreadyout (slvHreadyout[s]),
      .slvHrdata    (slvHrdata[s]),
      .slvHready    (slvHready[s]),
      .slvHresp     (slvHresp[s])
    );
  end

endmodule

`default_nettype wire

// File: design/ahbSwitchPkg.sv
// AHB switch package with bus widths, transfer encodings and phase structs
`default_nettype none

package ahbSwitchPkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  // Full 32-bit address and data path
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;

  //////////////////////////////
  // Transfer encodings
  //////////////////////////////

  // HTRANS as the AHB spec encodes it
  typedef enum logic [1:0] {
    TransIdle   = 2'b00,
    TransBusy   = 2'b01,
    TransNonseq = 2'b10,
    TransSeq    = 2'b11
  } htransT;

  // HSIZE, log2 of the byte count
  typedef logic [2:0] hsizeT;

  // HRESP value for a good transfer, ERROR is the other one
  localparam logic RespOkay = 1'b0;

  //////////////////////////////
  // Phase structs
  //////////////////////////////

  // One address phase as it travels through the switch
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    hsizeT                size;
    htransT               trans;
  } ahbReqT;

  // Data-phase return towards a master
  // ready doubles as the master's HREADYOUT
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 ready;
    logic                 resp;
  } ahbRespT;

endpackage

`default_nettype wire

// File: src.f
+incdir+verification
design/ahbSwitchPkg.sv
design/ahbArbiter.sv
design/ahbSlavePort.sv
design/ahbMasterPort.sv
design/ahbSwitch.sv
verification/ahbSwitchTb.sv

// File: verification/ahbSwitchTests.svh
// Directed tests for the AHB switch, included into the testbench module
`ifndef AHB_SWITCH_TESTS_SVH
`define AHB_SWITCH_TESTS_SVH

//////////////////////////////
// Reset and single master
//////////////////////////////

task automatic checkResetState();
  testCount++;
  @(negedge HCLK);
  for (int i = 0; i < 2; i++)
  begin
    if (mstResp[i].ready !== 1'b1)
      reportError($sformatf("master %0d ready after reset", i), mstResp[i].ready, 1'b1);
    if (slvHsel[i] !== 1'b0)
      reportError($sformatf("slave %0d hsel after reset", i), slvHsel[i], 1'b0);
    if (slvReq[i].trans !== ahbSwitchPkg::TransIdle)
      reportError($sformatf("slave %0d trans after reset", i), slvReq[i].trans,
                  ahbSwitchPkg::TransIdle);
  end
endtask

task automatic singleMasterAccess();
  logic [31:0] data [2];
  logic [31:0] addr [2];
  logic [31:0] rdata;
  logic        resp;
  testCount++;
  addr[0] = 32'h0000_0010;
  addr[1] = 32'h1000_0020;
  for (int s = 0; s < 2; s++)
  begin
    data[s] = $random(seed);
    selSeen = '0;
    runTransfer(0, 1'b1, addr[s], data[s], rdata, resp);
    if (resp !== 1'b0)
      reportError($sformatf("write resp to slave %0d", s), resp, 1'b0);
    // Only the region that decodes the address may be selected
    if (selSeen !== (2'b01 << s))
      reportError($sformatf("hsel seen on write to slave %0d", s), selSeen, 2'b01 << s);
  end
  for (int s = 0; s < 2; s++)
  begin
    selSeen = '0;
    runTransfer(0, 1'b0, addr[s], '0, rdata, resp);
    if (rdata !== data[s])
      reportError($sformatf("read data from slave %0d", s), rdata, data[s]);
    if (resp !== 1'b0)
      reportError($sformatf("read resp from slave %0d", s), resp, 1'b0);
    if (selSeen !== (2'b01 << s))
      reportError($sformatf("hsel seen on read from slave %0d", s), selSeen, 2'b01 << s);
  end
endtask

//////////////////////////////
// Wait states and contention
//////////////////////////////

// Slave 1 grant is parked on master 0 here, so only the slave stalls
task automatic waitStateRead();
  logic [31:0] data;
  logic [31:0] rdata;
  logic        resp;
  testCount++;
  data          = $random(seed);
  waitStates[1] = 3;
  watchWait     = 1'b1;
  runTransfer(0, 1'b1, 32'h1000_0030, data, rdata, resp);
  if (stallCycles[0] != 3)
    reportError("stall cycles on slave 1 write", stallCycles[0], 3);
  runTransfer(0, 1'b0, 32'h1000_0030, '0, rdata, resp);
  if (stallCycles[0] != 3)
    reportError("stall cycles on slave 1 read", stallCycles[0], 3);
  if (rdata !== data)
    reportError("read data after wait states", rdata, data);
  if (resp !== 1'b0)
    reportError("read resp after wait states", resp, 1'b0);
  watchWait     = 1'b0;
  waitStates[1] = 0;
endtask

task automatic masterContention();
  logic [31:0] data0;
  logic [31:0] data1;
  logic [31:0] rd0;
  logic [31:0] rd1;
  logic        resp0;
  logic        resp1;
  testCount++;
  data0 = $random(seed);
  data1 = $random(seed);
  // Same address edge, same slave, master 0 has priority
  fork
    runTransfer(0, 1'b1, 32'h0000_0040, data0, rd0, resp0);
    runTransfer(1, 1'b1, 32'h0000_0044, data1, rd1, resp1);
  join
  if (doneTime[0] >= doneTime[1])
    noteFailure("Master 1 finished its contended write no later than master 0");
  if (stallCycles[1] == 0)
    noteFailure("Master 1 was never stalled while master 0 owned slave 0");
  runTransfer(0, 1'b0, 32'h0000_0040, '0, rd0, resp0);
  if (rd0 !== data0)
    reportError("master 0 contended read back", rd0, data0);
  runTransfer(1, 1'b0, 32'h0000_0044, '0, rd1, resp1);
  if (rd1 !== data1)
    reportError("master 1 contended read back", rd1, data1);
endtask

//////////////////////////////
// Parallel layers and errors
//////////////////////////////

task automatic parallelLayers();
  logic [31:0] data0;
  logic [31:0] data1;
  logic [31:0] rd0;
  logic [31:0] rd1;
  logic        resp0;
  logic        resp1;
  testCount++;
  data0 = $random(seed);
  data1 = $random(seed);
  // Park slave 1 on master 1 and slave 0 on master 0
  runTransfer(1, 1'b1, 32'h1000_0050, data1, rd1, resp1);
  runTransfer(0, 1'b1, 32'h0000_0050, data0, rd0, resp0);
  fork
    runTransfer(0, 1'b1, 32'h0000_0054, data0, rd0, resp0);
    runTransfer(1, 1'b1, 32'h1000_0058, data1, rd1, resp1);
  join
  if (stallCycles[0] != 0 || stallCycles[1] != 0)
    noteFailure("A master was stalled during parallel writes to separate slaves");
  fork
    runTransfer(0, 1'b0, 32'h0000_0054, '0, rd0, resp0);
    runTransfer(1, 1'b0, 32'h1000_0058, '0, rd1, resp1);
  join
  if (stallCycles[0] != 0 || stallCycles[1] != 0)
    noteFailure("A master was stalled during parallel reads from separate slaves");
  if (rd0 !== data0)
    reportError("master 0 parallel read", rd0, data0);
  if (rd1 !== data1)
    reportError("master 1 parallel read", rd1, data1);
endtask

task automatic errorAndUnmapped();
  logic [31:0] rdata;
  logic        resp;
  testCount++;
  runTransfer(0, 1'b0, errAddr, '0, rdata, resp);
  if (resp !== 1'b1)
    reportError("resp for error address", resp, 1'b1);
  // The other master must stay clean
  if (mstResp[1].resp !== 1'b0)
    reportError("master 1 resp during master 0 error", mstResp[1].resp, 1'b0);
  selSeen = '0;
  runTransfer(0, 1'b0, 32'h2000_0000, '0, rdata, resp);
  if (resp !== 1'b0)
    reportError("resp for unmapped address", resp, 1'b0);
  if (selSeen !== 2'b00)
    reportError("hsel seen for unmapped address", selSeen, 2'b00);
  if (stallCycles[0] != 0)
    reportError("stall cycles for unmapped address", stallCycles[0], 0);
endtask

`endif

// File: verification/ahbSwitchTb.sv
// Testbench for the AHB switch with two masters and two memory slaves
`timescale 1ns/100ps
`default_nettype none

module ahbSwitchTb;

  // Tests take about a hundred cycles, so this only catches a hung bus
  localparam int TimeoutCycles = 2000;

  // State of one memory slave's data phase
  typedef struct packed {
    logic       active;
    logic       write;
    logic       err;
    logic [7:0] index;
    logic [3:0] waitLeft;
  } slaveStateT;

  logic                  HCLK;
  logic                  arstN;
  logic                  mstHsel      [2];
  ahbSwitchPkg::ahbReqT  mstReq       [2];
  logic [31:0]           mstHwdata    [2];
  logic                  mstHready    [2];
  ahbSwitchPkg::ahbRespT mstResp      [2];
  logic                  slvHsel      [2];
  ahbSwitchPkg::ahbReqT  slvReq       [2];
  logic [31:0]           slvHwdata    [2];
  logic                  slvHreadyout [2];
  logic [31:0]           slvHrdata    [2];
  logic                  slvHready    [2];
  logic                  slvHresp     [2];

  slaveStateT  slvState [2];
  logic [31:0] slvMem   [2][256];
  int          waitStates [2];
  logic [31:0] errAddr;
  int          seed;
  int          errorCount;
  int          testCount;
  int          cycleCount;
  int          stallCycles [2];
  time         doneTime [2];
  logic [1:0]  selSeen;
  logic        watchWait;

  ahbSwitch #(
    .NumMasters (2),
    .NumSlaves  (2),
    .SlaveBase  ({32'h1000_0000, 32'h0000_0000}),
    .SlaveMask  ({32'hF000_0000, 32'hF000_0000})
  ) u_ahbSwitch (
    .HCLK         (HCLK),
    .arstN        (arstN),
    .mstHsel      (mstHsel),
    .mstReq       (mstReq),
    .mstHwdata    (mstHwdata),
    .mstHready    (mstHready),
    .mstResp      (mstResp),
    .slvHsel      (slvHsel),
    .slvReq       (slvReq),
    .slvHwdata    (slvHwdata),
    .slvHreadyout (slvHreadyout),
    .slvHrdata    (slvHrdata),
    .slvHready    (slvHready),
    .slvHresp     (slvHresp)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // The switch is the only slave on each master bus, so HREADY is its HREADYOUT
  always_comb
  begin
    for (int m = 0; m < 2; m++)
      mstHready[m] = mstResp[m].ready;
  end

  //////////////////////////////
  // Memory slave models
  //////////////////////////////

  // Ready drops for waitLeft cycles, rdata only valid in the last one
  always_comb
  begin
    for (int s = 0; s < 2; s++)
    begin
      slvHready[s] = !slvState[s].active || (slvState[s].waitLeft == 4'd0);
      slvHresp[s]  = slvState[s].active && slvState[s].err;
      if (slvState[s].active && !slvState[s].write && slvState[s].waitLeft == 4'd0)
        slvHrdata[s] = slvMem[s][slvState[s].index];
      else
        slvHrdata[s] = '0;
    end
  end

  always @(posedge HCLK or negedge arstN)
  begin : slaveModel
    slaveStateT nextState;
    if (!arstN)
    begin
      for (int s = 0; s < 2; s++)
        slvState[s] <= '0;
    end
    else
    begin
      for (int s = 0; s < 2; s++)
      begin
        if (slvHreadyout[s])
        begin
          // Write data lands on the edge that ends the data phase
          if (slvState[s].active && slvState[s].write)
            slvMem[s][slvState[s].index] <= slvHwdata[s];
          nextState = '0;
          if (slvHsel[s] && (slvReq[s].trans == ahbSwitchPkg::TransNonseq ||
                             slvReq[s].trans == ahbSwitchPkg::TransSeq))
          begin
            nextState.active   = 1'b1;
            nextState.write    = slvReq[s].write;
            nextState.err      = (slvReq[s].addr == errAddr);
            nextState.index    = slvReq[s].addr[9:2];
            nextState.waitLeft = waitStates[s][3:0];
          end
          slvState[s] <= nextState;
        end
        else
        begin
          slvState[s].waitLeft <= slvState[s].waitLeft - 4'd1;
        end
      end
    end
  end

  //////////////////////////////
  // Checking helpers
  //////////////////////////////

  task automatic reportError(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    errorCount++;
    $display("error at %0t: %s, got %h expected %h", $time, what, got, expected);
  endtask

  task automatic noteFailure(input string msg);
    errorCount++;
    $display("%s (at time %0t)", msg, $time);
  endtask

  // Master 0 must not see ready while slave 1 inserts a wait state
  always @(negedge HCLK)
  begin
    if (watchWait && !slvHready[1] && mstResp[0].ready)
      reportError("master 0 ready during slave 1 wait state", mstResp[0].ready, 1'b0);
  end

  //////////////////////////////
  // Bus driver
  //////////////////////////////

  // One single transfer on master m, address phase then data phase
  task automatic runTransfer(input int m, input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic resp);
    ahbSwitchPkg::ahbReqT req;
    req.addr       = addr;
    req.write      = write;
    req.size       = 3'd2;
    req.trans      = ahbSwitchPkg::TransNonseq;
    stallCycles[m] = 0;
    @(posedge HCLK);
    mstHsel[m] <= 1'b1;
    mstReq[m]  <= req;
    // Address phase is taken on the first edge with HREADY high
    do
    begin
      @(negedge HCLK);
      selSeen = selSeen | {slvHsel[1], slvHsel[0]};
      if (!mstResp[m].ready)
        stallCycles[m]++;
    end
    while (!mstResp[m].ready);
    @(posedge HCLK);
    req.trans = ahbSwitchPkg::TransIdle;
    mstHsel[m]   <= 1'b0;
    mstReq[m]    <= req;
    mstHwdata[m] <= wdata;
    // Data phase ends on the next edge with HREADY high
    do
    begin
      @(negedge HCLK);
      selSeen = selSeen | {slvHsel[1], slvHsel[0]};
      if (!mstResp[m].ready)
        stallCycles[m]++;
    end
    while (!mstResp[m].ready);
    rdata       = mstResp[m].rdata;
    resp        = mstResp[m].resp;
    doneTime[m] = $time;
  endtask

`include "ahbSwitchTests.svh"

  //////////////////////////////
  // Run control
  //////////////////////////////

  initial
  begin
    seed       = 32'h81f4;
    errorCount = 0;
    testCount  = 0;
    selSeen    = '0;
    watchWait  = 1'b0;
    errAddr    = 32'h1000_0060;
    arstN      = 1'b0;
    for (int i = 0; i < 2; i++)
    begin
      mstHsel[i]    = 1'b0;
      mstReq[i]     = '0;
      mstHwdata[i]  = '0;
      waitStates[i] = 0;
      slvState[i]   = '0;
    end
    repeat (3) @(posedge HCLK);
    arstN <= 1'b1;
    checkResetState();
    singleMasterAccess();
    waitStateRead();
    masterContention();
    parallelLayers();
    errorAndUnmapped();
    @(posedge HCLK);
    $display("Summary: %0d tests run, %0d errors", testCount, errorCount);
    if (errorCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Hang guard
  initial
  begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge HCLK);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Summary: %0d tests run, %0d errors", testCount, errorCount);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
